// ==== hw/muldiv_pkg.sv ====
// ============================================================
// shared definitions for the RISC-V M-extension multiply/divide
// unit. Every RTL and testbench file uses these as muldiv_pkg::name
// ============================================================

package muldiv_pkg;

  // the unit only supports a 32-bit datapath
  localparam int XLEN = 32;

  // an operand or a result word
  typedef logic [XLEN-1:0] word_t;

  // a full double-width product
  typedef logic [2*XLEN-1:0] dword_t;

  // function code, equal to funct3 of the instruction
  typedef logic [2:0] fn_t;

  // multiply group, bit 2 clear
  localparam fn_t FN_MUL    = 3'd0;
  localparam fn_t FN_MULH   = 3'd1;
  localparam fn_t FN_MULHSU = 3'd2;
  localparam fn_t FN_MULHU  = 3'd3;

  // divide group, bit 2 set
  localparam fn_t FN_DIV    = 3'd4;
  localparam fn_t FN_DIVU   = 3'd5;
  localparam fn_t FN_REM    = 3'd6;
  localparam fn_t FN_REMU   = 3'd7;

  // issue to result strobe for the multiplier, one operand stage plus one product stage
  localparam int MUL_LATENCY = 2;

  // issue to result strobe for the divider
  // 1 setup cycle, 32 restoring iterations and 1 sign-fix cycle
  localparam int DIV_LATENCY = 34;

  // divider control FSM
  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_RUN,
    DIV_FIX
  } div_state_t;

endpackage

// ==== hw/muldiv_mul.sv ====
// ============================================================
// two-stage multiplier for MUL, MULH, MULHSU and MULHU
// accepts one issue per cycle and returns the result two cycles later
// ============================================================

`timescale 1ns/1ns

module muldiv_mul (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               op_vld,
  input  muldiv_pkg::fn_t    op_fn,
  input  muldiv_pkg::word_t  op_a,
  input  muldiv_pkg::word_t  op_b,
  output muldiv_pkg::word_t  result,
  output logic               result_vld
);

  // only the two low bits of the function code matter inside this block
  logic [1:0] fn_lo;
  logic       a_signed;
  logic       b_signed;

  // operands widened by one bit so a single signed multiply covers all signedness mixes
  logic signed [muldiv_pkg::XLEN:0]     a_q;
  logic signed [muldiv_pkg::XLEN:0]     b_q;
  logic                                 hi_q;
  logic signed [2*muldiv_pkg::XLEN+1:0] prod_full;
  muldiv_pkg::dword_t                   prod_q;
  logic                                 hi_qq;
  logic [muldiv_pkg::MUL_LATENCY-1:0]   vld_q;

  assign fn_lo = op_fn[1:0];

  // MULH and MULHSU treat a as signed, only MULH treats b as signed
  assign a_signed = (fn_lo == muldiv_pkg::FN_MULH[1:0]) ||
                    (fn_lo == muldiv_pkg::FN_MULHSU[1:0]);
  assign b_signed = (fn_lo == muldiv_pkg::FN_MULH[1:0]);

  // stage one captures the extended operands on an issue
  always_ff @(posedge clk) begin
    if (op_vld) begin
      a_q  <= {a_signed & op_a[muldiv_pkg::XLEN-1], op_a};
      b_q  <= {b_signed & op_b[muldiv_pkg::XLEN-1], op_b};
      // every code except MUL wants the upper word
      hi_q <= (fn_lo != muldiv_pkg::FN_MUL[1:0]);
    end
  end

  // 33x33 signed product, the low 64 bits are exact for every signedness mix
  assign prod_full = a_q * b_q;

  // stage two registers the product every cycle so back-to-back issues both progress
  always_ff @(posedge clk) begin
    prod_q <= prod_full[2*muldiv_pkg::XLEN-1:0];
    hi_qq  <= hi_q;
  end

  assign result = hi_qq ? prod_q[2*muldiv_pkg::XLEN-1:muldiv_pkg::XLEN]
                        : prod_q[muldiv_pkg::XLEN-1:0];

  // valid travels alongside the two data stages
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[muldiv_pkg::MUL_LATENCY-2:0], op_vld};
    end
  end

  assign result_vld = vld_q[muldiv_pkg::MUL_LATENCY-1];

endmodule

// ==== hw/muldiv_div.sv ====
// ============================================================
// iterative restoring divider for DIV, DIVU, REM and REMU
// fixed latency, busy stays high until the result strobe
// ============================================================

`timescale 1ns/1ns

module muldiv_div (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               op_vld,
  input  muldiv_pkg::fn_t    op_fn,
  input  muldiv_pkg::word_t  op_a,
  input  muldiv_pkg::word_t  op_b,
  output muldiv_pkg::word_t  result,
  output logic               result_vld,
  output logic               busy
);

  // counter wide enough for the iteration count
  localparam int CNT_W = $clog2(muldiv_pkg::DIV_LATENCY);

  logic [1:0]             fn_lo;
  logic                   is_signed;
  logic                   a_neg;
  logic                   b_neg;
  muldiv_pkg::word_t      abs_a;
  muldiv_pkg::word_t      abs_b;

  muldiv_pkg::div_state_t state_q;
  logic [CNT_W-1:0]       cnt_q;

  // operation record, held for the whole division
  logic                   is_rem_q;
  logic                   neg_quo_q;
  logic                   neg_rem_q;
  logic                   div_zero_q;
  logic                   ovf_q;
  muldiv_pkg::word_t      dividend_q;
  muldiv_pkg::word_t      divisor_q;

  // quo_q starts as the dividend and fills with quotient bits from the bottom
  muldiv_pkg::word_t      quo_q;
  muldiv_pkg::word_t      rem_q;

  logic [muldiv_pkg::XLEN:0] partial;
  logic [muldiv_pkg::XLEN:0] trial;
  muldiv_pkg::word_t         quo_fix;
  muldiv_pkg::word_t         rem_fix;

  assign fn_lo = op_fn[1:0];

  // DIV and REM are signed, DIVU and REMU are not
  assign is_signed = (fn_lo == muldiv_pkg::FN_DIV[1:0]) ||
                     (fn_lo == muldiv_pkg::FN_REM[1:0]);

  assign a_neg   = is_signed & op_a[muldiv_pkg::XLEN-1];
  assign b_neg   = is_signed & op_b[muldiv_pkg::XLEN-1];
  assign abs_a   = a_neg ? -op_a : op_a;
  assign abs_b   = b_neg ? -op_b : op_b;

  // one restoring step, shift in the next dividend bit and try to subtract
  assign partial = {rem_q, quo_q[muldiv_pkg::XLEN-1]};
  // partial is below twice the divisor, so bit XLEN of the difference is its sign
  assign trial   = partial - {1'b0, divisor_q};

  assign quo_fix = neg_quo_q ? -quo_q : quo_q;
  assign rem_fix = neg_rem_q ? -rem_q : rem_q;

  // control FSM, the load edge is the setup cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= muldiv_pkg::DIV_IDLE;
      cnt_q      <= '0;
      result_vld <= 1'b0;
    end else begin
      result_vld <= 1'b0;
      case (state_q)
        muldiv_pkg::DIV_IDLE: begin
          if (op_vld) begin
            state_q <= muldiv_pkg::DIV_RUN;
            // everything but the setup and fix cycles is spent iterating
            cnt_q   <= CNT_W'(muldiv_pkg::DIV_LATENCY - 2);
          end
        end
        muldiv_pkg::DIV_RUN: begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == CNT_W'(1)) begin
            state_q <= muldiv_pkg::DIV_FIX;
          end
        end
        muldiv_pkg::DIV_FIX: begin
          result_vld <= 1'b1;
          state_q    <= muldiv_pkg::DIV_IDLE;
        end
        default: begin
          state_q <= muldiv_pkg::DIV_IDLE;
        end
      endcase
    end
  end

  // datapath registers follow the FSM state
  always_ff @(posedge clk) begin
    if (state_q == muldiv_pkg::DIV_IDLE && op_vld) begin
      is_rem_q   <= fn_lo[1];
      // quotient is negative when exactly one operand is negative
      neg_quo_q  <= a_neg ^ b_neg;
      // remainder takes the sign of the dividend
      neg_rem_q  <= a_neg;
      div_zero_q <= (op_b == '0);
      // the only signed overflow is the most negative value divided by minus one
      ovf_q      <= is_signed && (op_a == {1'b1, {(muldiv_pkg::XLEN-1){1'b0}}}) &&
                    (op_b == '1);
      dividend_q <= op_a;
      divisor_q  <= abs_b;
      quo_q      <= abs_a;
      rem_q      <= '0;
    end else if (state_q == muldiv_pkg::DIV_RUN) begin
      if (!trial[muldiv_pkg::XLEN]) begin
        rem_q <= trial[muldiv_pkg::XLEN-1:0];
        quo_q <= {quo_q[muldiv_pkg::XLEN-2:0], 1'b1};
      end else begin
        rem_q <= partial[muldiv_pkg::XLEN-1:0];
        quo_q <= {quo_q[muldiv_pkg::XLEN-2:0], 1'b0};
      end
    end else if (state_q == muldiv_pkg::DIV_FIX) begin
      // RISC-V fixes the results of division by zero and of signed overflow
      if (div_zero_q) begin
        result <= is_rem_q ? dividend_q : '1;
      end else if (ovf_q) begin
        result <= is_rem_q ? '0 : dividend_q;
      end else begin
        result <= is_rem_q ? rem_fix : quo_fix;
      end
    end
  end

  // result_vld extends busy over the cycle the result is presented
  assign busy = (state_q != muldiv_pkg::DIV_IDLE) || result_vld;

endmodule

// ==== hw/muldiv_top.sv ====
// ============================================================
// multiply/divide unit top, steers an issue by function group
// and merges results, multiplies return after MUL_LATENCY cycles
// ============================================================

`timescale 1ns/1ns

module muldiv_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               op_vld,
  input  muldiv_pkg::fn_t    op_fn,
  input  muldiv_pkg::word_t  op_a,
  input  muldiv_pkg::word_t  op_b,
  output muldiv_pkg::word_t  result,
  output logic               result_vld,
  output logic               busy
);

  logic              mul_issue;
  logic              div_issue;
  muldiv_pkg::word_t mul_result;
  logic              mul_result_vld;
  muldiv_pkg::word_t div_result;
  logic              div_result_vld;

  // bit 2 of the function code marks the divide group
  assign mul_issue = op_vld & ~op_fn[2];
  assign div_issue = op_vld &  op_fn[2];

  muldiv_mul u_mul (
    .clk        (clk),
    .rst_n      (rst_n),
    .op_vld     (mul_issue),
    .op_fn      (op_fn),
    .op_a       (op_a),
    .op_b       (op_b),
    .result     (mul_result),
    .result_vld (mul_result_vld)
  );

  muldiv_div u_div (
    .clk        (clk),
    .rst_n      (rst_n),
    .op_vld     (div_issue),
    .op_fn      (op_fn),
    .op_a       (op_a),
    .op_b       (op_b),
    .result     (div_result),
    .result_vld (div_result_vld),
    .busy       (busy)
  );

  // the issue rule keeps the two strobes apart, the multiplier wins the mux anyway
  assign result     = mul_result_vld ? mul_result : div_result;
  assign result_vld = mul_result_vld | div_result_vld;

endmodule

// ==== test/muldiv_assertions.sv ====
// ============================================================
// concurrent checks on the issue rule and result latency,
// bound into every muldiv_top instance
// ============================================================

`timescale 1ns/1ns

module muldiv_assertions (
  input logic            clk,
  input logic            rst_n,
  input logic            op_vld,
  input muldiv_pkg::fn_t op_fn,
  input logic            result_vld,
  input logic            busy
);

  // the unit has no queue, an issue during a division would be lost
  no_issue_while_busy: assert property (
    @(posedge clk) disable iff (!rst_n) busy |-> !op_vld
  ) else $error("op_vld raised while busy is high");

  // a divide issue returns its strobe after the full iteration count
  div_latency: assert property (
    @(posedge clk) disable iff (!rst_n)
      (op_vld && op_fn[2]) |-> ##(muldiv_pkg::DIV_LATENCY) result_vld
  ) else $error("no divide result %0d cycles after issue", muldiv_pkg::DIV_LATENCY);

  // multiplies run through the two pipeline stages
  mul_latency: assert property (
    @(posedge clk) disable iff (!rst_n)
      (op_vld && !op_fn[2]) |-> ##(muldiv_pkg::MUL_LATENCY) result_vld
  ) else $error("no multiply result %0d cycles after issue", muldiv_pkg::MUL_LATENCY);

  outputs_known: assert property (
    @(posedge clk) disable iff (!rst_n) !$isunknown({result_vld, busy})
  ) else $error("result_vld or busy unknown after reset");

endmodule

bind muldiv_top muldiv_assertions u_assertions (
  .clk        (clk),
  .rst_n      (rst_n),
  .op_vld     (op_vld),
  .op_fn      (op_fn),
  .result_vld (result_vld),
  .busy       (busy)
);

// ==== test/muldiv_tb.sv ====
// ============================================================
// directed testbench for the multiply/divide unit, checks every
// M-extension operation against a reference model of the ISA rules
// ============================================================

`timescale 1ns/1ns

module muldiv_tb;

  // headroom over the number of operations the tests issue, sizes the watchdog
  localparam int MAX_OPS = 200;

  logic              clk;
  logic              rst_n;
  logic              op_vld;
  muldiv_pkg::fn_t   op_fn;
  muldiv_pkg::word_t op_a;
  muldiv_pkg::word_t op_b;
  muldiv_pkg::word_t result;
  logic              result_vld;
  logic              busy;

  int errors = 0;
  int issued = 0;
  // number of rising edges seen so far
  int cycle  = 0;

  // outstanding operations in issue order, with the cycle their result is due
  muldiv_pkg::fn_t   pend_fn[$];
  muldiv_pkg::word_t pend_a[$];
  muldiv_pkg::word_t pend_b[$];
  int                pend_due[$];

  // zero, one, minus one, most negative, most positive
  muldiv_pkg::word_t corners[5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};

  muldiv_top dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .op_vld     (op_vld),
    .op_fn      (op_fn),
    .op_a       (op_a),
    .op_b       (op_b),
    .result     (result),
    .result_vld (result_vld),
    .busy       (busy)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle = cycle + 1;
  end

  // reference model built from the M-extension rules
  function automatic muldiv_pkg::word_t expected_result(input muldiv_pkg::fn_t fn,
      input muldiv_pkg::word_t a, input muldiv_pkg::word_t b);
    muldiv_pkg::dword_t sa;
    muldiv_pkg::dword_t ua;
    muldiv_pkg::dword_t sb;
    muldiv_pkg::dword_t ub;
    muldiv_pkg::dword_t prod;
    sa = {{32{a[31]}}, a};
    ua = {32'h0, a};
    sb = {{32{b[31]}}, b};
    ub = {32'h0, b};
    // low 64 bits of the extended product are exact for every signedness mix
    case (fn)
      muldiv_pkg::FN_MULH:   prod = sa * sb;
      muldiv_pkg::FN_MULHSU: prod = sa * ub;
      default:               prod = ua * ub;
    endcase
    if (!fn[2]) begin
      return (fn == muldiv_pkg::FN_MUL) ? prod[31:0] : prod[63:32];
    end
    // bit 1 picks the remainder, bit 0 marks the unsigned forms
    if (b == '0) begin
      return fn[1] ? a : '1;
    end
    if (!fn[0] && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      return fn[1] ? '0 : a;
    end
    // SystemVerilog division truncates toward zero, the remainder follows the dividend
    case (fn)
      muldiv_pkg::FN_DIV:  return $signed(a) / $signed(b);
      muldiv_pkg::FN_DIVU: return a / b;
      muldiv_pkg::FN_REM:  return $signed(a) % $signed(b);
      default:             return a % b;
    endcase
  endfunction

  // called 10 ns after a rising edge, returns at the same phase one cycle later
  task automatic issue(input muldiv_pkg::fn_t fn, input muldiv_pkg::word_t a,
      input muldiv_pkg::word_t b);
    // hold off while a division is running
    while (busy) begin
      @(posedge clk);
      #10;
    end
    op_vld = 1'b1;
    op_fn  = fn;
    op_a   = a;
    op_b   = b;
    pend_fn.push_back(fn);
    pend_a.push_back(a);
    pend_b.push_back(b);
    pend_due.push_back(cycle + (fn[2] ? muldiv_pkg::DIV_LATENCY : muldiv_pkg::MUL_LATENCY));
    issued++;
    @(posedge clk);
    #10;
    op_vld = 1'b0;
  endtask

  // wait until every outstanding result has come back
  task automatic drain();
    int waited;
    waited = 0;
    while (pend_fn.size() != 0 && waited < 2 * muldiv_pkg::DIV_LATENCY) begin
      @(negedge clk);
      waited++;
    end
    if (pend_fn.size() != 0) begin
      $display("timeout at %0t: %0d results never arrived", $time, pend_fn.size());
      errors += pend_fn.size();
      pend_fn.delete();
      pend_a.delete();
      pend_b.delete();
      pend_due.delete();
    end
    @(posedge clk);
    #10;
  endtask

  task automatic idle_check();
    assert (!result_vld && !busy) else begin
      $display("error %0t: result_vld %b busy %b, both should be low", $time, result_vld, busy);
      errors++;
    end
  endtask

  task automatic mul_family_test();
    for (int f = 0; f < 4; f++) begin
      // every pair of corner operands, then random ones
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          issue(muldiv_pkg::fn_t'(f), corners[i], corners[j]);
        end
      end
      repeat (8) begin
        issue(muldiv_pkg::fn_t'(f), $urandom, $urandom);
      end
      drain();
    end
  endtask

  task automatic mul_pipeline_test();
    // mixed multiply codes back to back, results must leave in issue order
    repeat (8) begin
      issue(muldiv_pkg::fn_t'($urandom_range(3)), $urandom, $urandom);
    end
    drain();
  endtask

  task automatic div_family_test();
    for (int f = 4; f < 8; f++) begin
      // shifted divisors give small as well as large quotients
      repeat (8) begin
        issue(muldiv_pkg::fn_t'(f), $urandom, $urandom >> $urandom_range(31));
      end
      issue(muldiv_pkg::fn_t'(f), $urandom, '0);
      // signed overflow for DIV and REM, a plain division for the unsigned codes
      issue(muldiv_pkg::fn_t'(f), 32'h8000_0000, 32'hffff_ffff);
    end
    drain();
  endtask

  task automatic busy_test();
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    issue(muldiv_pkg::FN_DIVU, $urandom, $urandom_range(255, 1));
    // busy holds from the issue through the cycle of the result strobe
    while (!seen && waited < 2 * muldiv_pkg::DIV_LATENCY) begin
      assert (busy) else begin
        $display("error %0t: busy dropped %0d cycles into a division", $time, waited);
        errors++;
      end
      seen = result_vld;
      if (!seen) begin
        @(posedge clk);
        #10;
        waited++;
      end
    end
    @(posedge clk);
    #10;
    assert (!busy) else begin
      $display("error %0t: busy still high after the division result", $time);
      errors++;
    end
    // a multiply on the very next free cycle completes at its own latency
    issue(muldiv_pkg::FN_MULHU, $urandom, $urandom);
    drain();
  endtask

  // scoreboard, each strobe must match the oldest outstanding operation
  initial begin
    muldiv_pkg::word_t want;
    forever begin
      @(negedge clk);
      if (rst_n && result_vld) begin
        if (pend_fn.size() == 0) begin
          $display("error %0t: result strobe with no operation outstanding", $time);
          errors++;
        end else begin
          want = expected_result(pend_fn[0], pend_a[0], pend_b[0]);
          assert (result === want && cycle == pend_due[0]) else begin
            $display("error %0t: fn %0d a %h b %h expected %h at cycle %0d, got %h at cycle %0d",
                     $time, pend_fn[0], pend_a[0], pend_b[0], want, pend_due[0], result, cycle);
            errors++;
          end
          void'(pend_fn.pop_front());
          void'(pend_a.pop_front());
          void'(pend_b.pop_front());
          void'(pend_due.pop_front());
        end
      end
    end
  end

  // watchdog, 40 cycles for each possible operation plus margin
  initial begin
    repeat (MAX_OPS * 40 + 100) @(posedge clk);
    $display("watchdog expired at %0t, the run hung", $time);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'h3f9ea6ce));
    rst_n  = 1'b0;
    op_vld = 1'b0;
    op_fn  = '0;
    op_a   = '0;
    op_b   = '0;
    // outputs stay low through the 4 reset cycles and just after release
    repeat (4) begin
      @(posedge clk);
      #10;
      idle_check();
    end
    rst_n = 1'b1;
    repeat (2) begin
      @(posedge clk);
      #10;
      idle_check();
    end
    mul_family_test();
    mul_pipeline_test();
    div_family_test();
    busy_test();
    $display("%0d operations issued, %0d errors", issued, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== muldiv.f ====
hw/muldiv_pkg.sv
hw/muldiv_mul.sv
hw/muldiv_div.sv
hw/muldiv_top.sv
test/muldiv_assertions.sv
test/muldiv_tb.sv

// ==== Bender.yml ====
package:
  name: muldiv

sources:
  # RTL, package first
  - hw/muldiv_pkg.sv
  - hw/muldiv_mul.sv
  - hw/muldiv_div.sv
  - hw/muldiv_top.sv
  # testbench and bound assertions
  - target: test
    files:
      - test/muldiv_assertions.sv
      - test/muldiv_tb.sv
